// ==== Bender.yml ====
package:
  name: core_bus_adapter

export_include_dirs:
  - .

sources:
  - files:
      - core_bus_pkg.sv
      - obi_wb_fsm.sv
      - bus_timeout_timer.sv
      - irq_pending_map.sv
      - core_bus_adapter_top.sv
  - target: test
    files:
      - tb_core_bus_adapter.sv

// ==== bus_timeout_timer.sv ====
`timescale 1ns/1ps

`include "core_bus_consts.svh"

module bus_timeout_timer (
  input  logic clk_i,
  input  logic rst_i,
  // High while the bridge waits on the slave
  input  logic busy_i,
  // Wait limit reached
  output logic expired_o
);

  // Wide enough to hold the limit itself
  localparam int unsigned CNT_W = $clog2(`CB_TIMEOUT_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`CB_TIMEOUT_CYCLES);

  logic [CNT_W-1:0] cnt_q;

  // ------------------------------------------------------------
  // Wait counter
  // ------------------------------------------------------------
  // Cleared between cycles, saturates at the limit
  always_ff @(posedge clk_i) begin
    if (rst_i || !busy_i) begin
      cnt_q <= '0;
    end else if (cnt_q != CNT_MAX) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Only meaningful while a cycle is open
  assign expired_o = busy_i && (cnt_q == CNT_MAX);

endmodule

// ==== core_bus_adapter_top.f ====
+incdir+.
core_bus_pkg.sv
obi_wb_fsm.sv
bus_timeout_timer.sv
irq_pending_map.sv
core_bus_adapter_top.sv
tb_core_bus_adapter.sv

// ==== core_bus_adapter_top.sv ====
`timescale 1ns/1ps

module core_bus_adapter_top
  import core_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  // Instruction OBI
  input  logic        instr_req_i,
  input  word_t       instr_addr_i,
  output logic        instr_gnt_o,
  output logic        instr_rvalid_o,
  output word_t       instr_rdata_o,
  output logic        instr_err_o,
  // Instruction Wishbone
  output logic        instr_wb_cyc_o,
  output logic        instr_wb_stb_o,
  output word_t       instr_wb_adr_o,
  input  word_t       instr_wb_dat_i,
  input  logic        instr_wb_ack_i,
  // Data OBI
  input  logic        data_req_i,
  input  logic        data_we_i,
  input  strb_t       data_be_i,
  input  word_t       data_addr_i,
  input  word_t       data_wdata_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o,
  output word_t       data_rdata_o,
  output logic        data_err_o,
  // Data Wishbone
  output logic        data_wb_cyc_o,
  output logic        data_wb_stb_o,
  output logic        data_wb_we_o,
  output strb_t       data_wb_sel_o,
  output word_t       data_wb_adr_o,
  output word_t       data_wb_dat_o,
  input  word_t       data_wb_dat_i,
  input  logic        data_wb_ack_i,
  // Interrupt and debug
  input  word_t       irq_a_i,
  input  word_t       irq_b_i,
  input  logic        irq_ack_i,
  input  logic [4:0]  irq_id_i,
  input  logic        debug_req_a_i,
  input  logic        debug_req_b_i,
  output logic        irq_software_o,
  output logic        irq_timer_o,
  output logic        irq_external_o,
  output logic        irq_nm_o,
  output logic [14:0] irq_fast_o,
  output logic        debug_req_o
);

  logic instr_busy;
  logic instr_expired;
  logic data_busy;
  logic data_expired;

  // ------------------------------------------------------------
  // Instruction port, read only
  // ------------------------------------------------------------
  obi_wb_fsm #(
    .READ_ONLY (1'b1)
  ) u_instr_bridge (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (instr_req_i),
    .we_i      (1'b0),
    .addr_i    (instr_addr_i),
    .wdata_i   ('0),
    .be_i      ('1),
    .gnt_o     (instr_gnt_o),
    .rvalid_o  (instr_rvalid_o),
    .err_o     (instr_err_o),
    .rdata_o   (instr_rdata_o),
    .wb_cyc_o  (instr_wb_cyc_o),
    .wb_stb_o  (instr_wb_stb_o),
    .wb_we_o   (),
    .wb_adr_o  (instr_wb_adr_o),
    .wb_dat_o  (),
    .wb_sel_o  (),
    .wb_dat_i  (instr_wb_dat_i),
    .wb_ack_i  (instr_wb_ack_i),
    .busy_o    (instr_busy),
    .expired_i (instr_expired)
  );

  bus_timeout_timer u_instr_timer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .busy_i    (instr_busy),
    .expired_o (instr_expired)
  );

  // ------------------------------------------------------------
  // Data port, read/write
  // ------------------------------------------------------------
  obi_wb_fsm #(
    .READ_ONLY (1'b0)
  ) u_data_bridge (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (data_req_i),
    .we_i      (data_we_i),
    .addr_i    (data_addr_i),
    .wdata_i   (data_wdata_i),
    .be_i      (data_be_i),
    .gnt_o     (data_gnt_o),
    .rvalid_o  (data_rvalid_o),
    .err_o     (data_err_o),
    .rdata_o   (data_rdata_o),
    .wb_cyc_o  (data_wb_cyc_o),
    .wb_stb_o  (data_wb_stb_o),
    .wb_we_o   (data_wb_we_o),
    .wb_adr_o  (data_wb_adr_o),
    .wb_dat_o  (data_wb_dat_o),
    .wb_sel_o  (data_wb_sel_o),
    .wb_dat_i  (data_wb_dat_i),
    .wb_ack_i  (data_wb_ack_i),
    .busy_o    (data_busy),
    .expired_i (data_expired)
  );

  bus_timeout_timer u_data_timer (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .busy_i    (data_busy),
    .expired_o (data_expired)
  );

  // ------------------------------------------------------------
  // Interrupt and debug merge
  // ------------------------------------------------------------
  irq_pending_map u_irq_map (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .irq_a_i        (irq_a_i),
    .irq_b_i        (irq_b_i),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i),
    .debug_req_a_i  (debug_req_a_i),
    .debug_req_b_i  (debug_req_b_i),
    .irq_software_o (irq_software_o),
    .irq_timer_o    (irq_timer_o),
    .irq_external_o (irq_external_o),
    .irq_nm_o       (irq_nm_o),
    .irq_fast_o     (irq_fast_o),
    .debug_req_o    (debug_req_o)
  );

endmodule

// ==== core_bus_consts.svh ====
`ifndef CORE_BUS_CONSTS_SVH
`define CORE_BUS_CONSTS_SVH

// ------------------------------------------------------------
// Bus widths
// ------------------------------------------------------------
`define CB_ADDR_W 32
`define CB_DATA_W 32

// ------------------------------------------------------------
// Interrupt vector bit positions, core input map
// ------------------------------------------------------------
`define CB_IRQ_SW      3
`define CB_IRQ_TIMER   7
`define CB_IRQ_EXT     11
`define CB_IRQ_FAST_LO 16
`define CB_IRQ_FAST_HI 30
`define CB_IRQ_NM      31

// Strobe cycles without ack before the bridge gives up
`define CB_TIMEOUT_CYCLES 16

`endif

// ==== core_bus_input.txt ====
// kind_addr_wdata_be_delay_irqa_irqb_dbg_ack_exprdata_experr_expirq_expdbg
// kind 0 instr read, 1 data read, 2 data write, 3 irq step; delay ff no ack; ack 8x id x
2_00000040_11223344_f_00_00000000_00000000_0_00_00000000_0_00000000_0
1_00000040_00000000_f_02_00000000_00000000_0_00_11223344_0_00000000_0
2_00000040_aabbccdd_5_01_00000000_00000000_0_00_00000000_0_00000000_0
1_00000040_00000000_f_00_00000000_00000000_0_00_11bb33dd_0_00000000_0
2_00000084_55667788_c_03_00000000_00000000_0_00_00000000_0_00000000_0
1_00000084_00000000_f_01_00000000_00000000_0_00_5566be6b_0_00000000_0
0_00000100_00000000_f_05_00000000_00000000_0_00_deadbfef_0_00000000_0
0_00000104_00000000_f_00_00000000_00000000_0_00_deadbfeb_0_00000000_0
0_00000200_00000000_f_ff_00000000_00000000_0_00_00000000_1_00000000_0
0_00000208_00000000_f_01_00000000_00000000_0_00_deadbce7_0_00000000_0
1_00000300_00000000_f_ff_00000000_00000000_0_00_00000000_1_00000000_0
2_00000300_cafef00d_f_ff_00000000_00000000_0_00_00000000_1_00000000_0
1_00000300_00000000_f_04_00000000_00000000_0_00_deadbdef_0_00000000_0
0_00000040_00000000_f_00_00000000_00000000_0_00_deadbeaf_0_00000000_0
3_00000000_00000000_0_00_00000008_00000000_0_00_00000000_0_00000008_0
3_00000000_00000000_0_00_00000008_00000080_0_00_00000000_0_00000088_0
3_00000000_00000000_0_00_00000800_00000000_0_00_00000000_0_00000888_0
3_00000000_00000000_0_00_00000000_80010000_0_00_00000000_0_80010888_0
3_00000000_00000000_0_00_40000000_00000000_1_00_00000000_0_c0010888_1
3_00000000_00000000_0_00_00000000_00000000_2_83_00000000_0_c0010880_1
3_00000000_00000000_0_00_00000080_00000000_0_87_00000000_0_c0010800_0
3_00000000_00000000_0_00_00000080_00000000_0_00_00000000_0_c0010880_0
3_00000000_00000000_0_00_00000000_00000000_0_9f_00000000_0_40010880_0
3_00000000_00000000_0_00_00000000_00000000_0_90_00000000_0_40000880_0
3_00000000_00000000_0_00_00000000_00000000_0_9e_00000000_0_00000880_0
3_00000000_00000000_0_00_00000000_00000000_0_8b_00000000_0_00000080_0
3_00000000_00000000_0_00_00000000_00000000_3_87_00000000_0_00000000_1
3_00000000_00000000_0_00_00000000_00000000_0_00_00000000_0_00000000_0

// ==== core_bus_pkg.sv ====
`include "core_bus_consts.svh"

package core_bus_pkg;

  // ------------------------------------------------------------
  // Bridge FSM encoding
  // ------------------------------------------------------------
  // IDLE      waiting for an OBI request, grant given here
  // WB_CYCLE  cyc/stb asserted, waiting for ack or timeout
  // RESPOND   one cycle of rvalid towards the core
  typedef enum logic [1:0] {
    IDLE     = 2'b00,
    WB_CYCLE = 2'b01,
    RESPOND  = 2'b10
  } bridge_state_e;

  // ------------------------------------------------------------
  // Payload types
  // ------------------------------------------------------------
  // Full data word, also used for addresses
  typedef logic [`CB_DATA_W-1:0] word_t;

  // One enable bit per byte lane
  typedef logic [`CB_DATA_W/8-1:0] strb_t;

endpackage

// ==== irq_pending_map.sv ====
`timescale 1ns/1ps

`include "core_bus_consts.svh"

module irq_pending_map
  import core_bus_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  // Two interrupt sources, same bit map
  input  word_t       irq_a_i,
  input  word_t       irq_b_i,
  // Acknowledge from the core
  input  logic        irq_ack_i,
  input  logic [4:0]  irq_id_i,
  // Debug request sources
  input  logic        debug_req_a_i,
  input  logic        debug_req_b_i,
  // Core interrupt inputs
  output logic        irq_software_o,
  output logic        irq_timer_o,
  output logic        irq_external_o,
  output logic        irq_nm_o,
  output logic [14:0] irq_fast_o,
  output logic        debug_req_o
);

  word_t pending_q;
  word_t pending_d;
  word_t irq_set;
  word_t irq_clr;
  logic  debug_req_q;

  // ------------------------------------------------------------
  // Pending register
  // ------------------------------------------------------------
  // Either source sets the bit
  assign irq_set = irq_a_i | irq_b_i;

  // One-hot clear from the ack id
  always_comb begin
    irq_clr = '0;
    if (irq_ack_i) begin
      irq_clr[irq_id_i] = 1'b1;
    end
  end

  // Clear beats set in the same cycle
  assign pending_d = (pending_q | irq_set) & ~irq_clr;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

  // Merged debug request, one cycle late
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      debug_req_q <= 1'b0;
    end else begin
      debug_req_q <= debug_req_a_i | debug_req_b_i;
    end
  end

  // ------------------------------------------------------------
  // Map onto core inputs
  // ------------------------------------------------------------
  assign irq_software_o = pending_q[`CB_IRQ_SW];
  assign irq_timer_o    = pending_q[`CB_IRQ_TIMER];
  assign irq_external_o = pending_q[`CB_IRQ_EXT];
  // Fast lines 0..14 sit at bits 16..30
  assign irq_fast_o     = pending_q[`CB_IRQ_FAST_HI:`CB_IRQ_FAST_LO];
  assign irq_nm_o       = pending_q[`CB_IRQ_NM];
  assign debug_req_o    = debug_req_q;

endmodule

// ==== obi_wb_fsm.sv ====
`timescale 1ns/1ps

`include "core_bus_consts.svh"

module obi_wb_fsm
  import core_bus_pkg::*;
#(
  // Instruction port variant, no writes
  parameter bit READ_ONLY = 1'b0
) (
  input  logic  clk_i,
  input  logic  rst_i,
  // OBI request
  input  logic  req_i,
  input  logic  we_i,
  input  word_t addr_i,
  input  word_t wdata_i,
  input  strb_t be_i,
  // OBI grant and response
  output logic  gnt_o,
  output logic  rvalid_o,
  output logic  err_o,
  output word_t rdata_o,
  // Wishbone classic master
  output logic  wb_cyc_o,
  output logic  wb_stb_o,
  output logic  wb_we_o,
  output word_t wb_adr_o,
  output word_t wb_dat_o,
  output strb_t wb_sel_o,
  input  word_t wb_dat_i,
  input  logic  wb_ack_i,
  // Timeout timer handshake
  output logic  busy_o,
  input  logic  expired_i
);

  bridge_state_e         state_q;
  bridge_state_e         state_d;
  logic                  accept;
  logic                  done;
  logic [`CB_ADDR_W-1:0] adr_q;
  word_t                 dat_q;
  strb_t                 sel_q;
  logic                  we_q;
  word_t                 rdata_q;
  logic                  err_q;

  // ------------------------------------------------------------
  // Handshake decode
  // ------------------------------------------------------------
  // Grant only from IDLE, one open transaction
  assign accept = (state_q == IDLE) && req_i;
  // Cycle ends on ack, or on timeout if no ack
  assign done   = (state_q == WB_CYCLE) && (wb_ack_i || expired_i);

  // ------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_i) begin
          state_d = WB_CYCLE;
        end
      end
      WB_CYCLE: begin
        if (done) begin
          state_d = RESPOND;
        end
      end
      // Response lasts a single cycle
      RESPOND: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request fields latched at grant, held through the cycle
  always_ff @(posedge clk_i) begin
    if (accept) begin
      adr_q <= addr_i;
      dat_q <= READ_ONLY ? '0 : wdata_i;
      sel_q <= READ_ONLY ? '1 : be_i;
      we_q  <= READ_ONLY ? 1'b0 : we_i;
    end
  end

  // Read data capture, zero on timeout or write
  always_ff @(posedge clk_i) begin
    if (done) begin
      if (wb_ack_i && !we_q) begin
        rdata_q <= wb_dat_i;
      end else begin
        rdata_q <= '0;
      end
    end
  end

  // Error flag, set only when timer fired without ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      err_q <= 1'b0;
    end else if (done) begin
      err_q <= !wb_ack_i;
    end
  end

  // ------------------------------------------------------------
  // Outputs
  // ------------------------------------------------------------
  assign gnt_o    = accept;
  assign rvalid_o = (state_q == RESPOND);
  assign rdata_o  = rdata_q;
  assign err_o    = err_q;

  // cyc and stb together for the whole wait
  assign wb_cyc_o = (state_q == WB_CYCLE);
  assign wb_stb_o = (state_q == WB_CYCLE);
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = sel_q;

  // Timer runs while strobe is out
  assign busy_o   = (state_q == WB_CYCLE);

endmodule

// ==== tb_core_bus_adapter.sv ====
`timescale 1ns/1ps

`include "core_bus_consts.svh"

// ------------------------------------------------------------
// Wishbone classic slave with a programmable ack delay
// ------------------------------------------------------------
module wb_slave_model (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        cyc_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  // Extra wait cycles where all ones means no ack at all
  input  logic [7:0]  delay_i,
  output logic        ack_o,
  output logic [31:0] dat_o
);

  // Small tagged store where unwritten words read back the fill pattern
  logic [31:0] mem [16];
  logic [31:0] tag [16];
  logic        vld [16];
  logic [7:0]  wait_cnt;
  logic [3:0]  idx;
  logic [31:0] word;

  function automatic logic [31:0] fill_word(input logic [31:0] adr);
    return adr ^ 32'hdead_beef;
  endfunction

  always @(posedge clk_i) begin
    idx  = adr_i[5:2];
    word = (vld[idx] && (tag[idx] == adr_i)) ? mem[idx] : fill_word(adr_i);
    if (rst_i) begin
      ack_o    <= 1'b0;
      dat_o    <= '0;
      wait_cnt <= '0;
      for (int k = 0; k < 16; k++) begin
        vld[k] <= 1'b0;
      end
    end else if (cyc_i && stb_i && !ack_o) begin
      if ((delay_i != 8'hff) && (wait_cnt == delay_i)) begin
        ack_o    <= 1'b1;
        wait_cnt <= '0;
        if (we_i) begin
          // Byte lane merge under sel
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              word[8*b +: 8] = dat_i[8*b +: 8];
            end
          end
          mem[idx] <= word;
          tag[idx] <= adr_i;
          vld[idx] <= 1'b1;
          dat_o    <= '0;
        end else begin
          dat_o <= word;
        end
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end else begin
      // Single cycle ack and counter restart between cycles
      ack_o <= 1'b0;
      if (!stb_i) begin
        wait_cnt <= '0;
      end
    end
  end

endmodule

module tb_core_bus_adapter;

  localparam int NUM_VEC  = 28;
  localparam int CLK_HALF = 4;
  // Per step budget covers the gap, the grant and a full timeout
  localparam int WATCHDOG_CYCLES = NUM_VEC * (`CB_TIMEOUT_CYCLES + 40) + 8;

  logic        clk;
  logic        rst;
  // Instruction port
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        instr_gnt, instr_rvalid, instr_err;
  logic [31:0] instr_rdata;
  logic        instr_wb_cyc, instr_wb_stb, instr_wb_ack;
  logic [31:0] instr_wb_adr, instr_wb_dat_r;
  logic [7:0]  instr_delay;
  // Data port
  logic        data_req, data_we;
  logic [3:0]  data_be;
  logic [31:0] data_addr, data_wdata;
  logic        data_gnt, data_rvalid, data_err;
  logic [31:0] data_rdata;
  logic        data_wb_cyc, data_wb_stb, data_wb_we, data_wb_ack;
  logic [3:0]  data_wb_sel;
  logic [31:0] data_wb_adr, data_wb_dat_w, data_wb_dat_r;
  logic [7:0]  data_delay;
  // Interrupt and debug
  logic [31:0] irq_a, irq_b;
  logic        irq_ack;
  logic [4:0]  irq_id;
  logic        debug_req_a, debug_req_b;
  logic        irq_software, irq_timer, irq_external, irq_nm;
  logic [14:0] irq_fast;
  logic        debug_req;

  // One vector per line of 57 hex digits
  logic [227:0] vectors [NUM_VEC];
  logic [227:0] vec;
  int unsigned  seed;
  int unsigned  gap;

  always #(CLK_HALF) clk = ~clk;

  core_bus_adapter_top i_dut (
    .clk_i          (clk),
    .rst_i          (rst),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .instr_err_o    (instr_err),
    .instr_wb_cyc_o (instr_wb_cyc),
    .instr_wb_stb_o (instr_wb_stb),
    .instr_wb_adr_o (instr_wb_adr),
    .instr_wb_dat_i (instr_wb_dat_r),
    .instr_wb_ack_i (instr_wb_ack),
    .data_req_i     (data_req),
    .data_we_i      (data_we),
    .data_be_i      (data_be),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata),
    .data_err_o     (data_err),
    .data_wb_cyc_o  (data_wb_cyc),
    .data_wb_stb_o  (data_wb_stb),
    .data_wb_we_o   (data_wb_we),
    .data_wb_sel_o  (data_wb_sel),
    .data_wb_adr_o  (data_wb_adr),
    .data_wb_dat_o  (data_wb_dat_w),
    .data_wb_dat_i  (data_wb_dat_r),
    .data_wb_ack_i  (data_wb_ack),
    .irq_a_i        (irq_a),
    .irq_b_i        (irq_b),
    .irq_ack_i      (irq_ack),
    .irq_id_i       (irq_id),
    .debug_req_a_i  (debug_req_a),
    .debug_req_b_i  (debug_req_b),
    .irq_software_o (irq_software),
    .irq_timer_o    (irq_timer),
    .irq_external_o (irq_external),
    .irq_nm_o       (irq_nm),
    .irq_fast_o     (irq_fast),
    .debug_req_o    (debug_req)
  );

  // Instruction slave sees full-word reads only
  wb_slave_model u_instr_slave (
    .clk_i   (clk),
    .rst_i   (rst),
    .cyc_i   (instr_wb_cyc),
    .stb_i   (instr_wb_stb),
    .we_i    (1'b0),
    .sel_i   (4'hf),
    .adr_i   (instr_wb_adr),
    .dat_i   (32'h0),
    .delay_i (instr_delay),
    .ack_o   (instr_wb_ack),
    .dat_o   (instr_wb_dat_r)
  );

  wb_slave_model u_data_slave (
    .clk_i   (clk),
    .rst_i   (rst),
    .cyc_i   (data_wb_cyc),
    .stb_i   (data_wb_stb),
    .we_i    (data_wb_we),
    .sel_i   (data_wb_sel),
    .adr_i   (data_wb_adr),
    .dat_i   (data_wb_dat_w),
    .delay_i (data_delay),
    .ack_o   (data_wb_ack),
    .dat_o   (data_wb_dat_r)
  );

  // ------------------------------------------------------------
  // Failure reporting and compare
  // ------------------------------------------------------------
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (act_v !== exp_v) begin
      abort_run($sformatf("[ERROR] t=%0t %s expected %h actual %h",
                          $time, name, exp_v, act_v));
    end
  endtask

  // ------------------------------------------------------------
  // One OBI transaction for kinds 0 to 2
  // ------------------------------------------------------------
  task automatic run_bus(input logic [227:0] v);
    logic        is_instr;
    logic [31:0] addr;
    logic [7:0]  delay;
    logic        stb, cyc, ack, rvalid, gnt;
    int          cnt;
    int          ack_at;
    string       pfx;
    is_instr = (v[227:224] == 4'h0);
    addr     = v[223:192];
    delay    = v[155:148];
    pfx      = is_instr ? "instr" : "data";
    @(posedge clk);
    if (is_instr) begin
      instr_req   <= 1'b1;
      instr_addr  <= addr;
      instr_delay <= delay;
    end else begin
      data_req   <= 1'b1;
      data_we    <= (v[227:224] == 4'h2);
      data_be    <= v[159:156];
      data_addr  <= addr;
      data_wdata <= v[191:160];
      data_delay <= delay;
    end
    // Grant in the request cycle from IDLE
    @(negedge clk);
    check_value({pfx, "_gnt_o"}, 32'd1, is_instr ? instr_gnt : data_gnt);
    cnt    = 0;
    ack_at = -1;
    // Request stays up so any grant here would be a second one
    do begin
      @(negedge clk);
      cnt++;
      stb    = is_instr ? instr_wb_stb : data_wb_stb;
      cyc    = is_instr ? instr_wb_cyc : data_wb_cyc;
      ack    = is_instr ? instr_wb_ack : data_wb_ack;
      rvalid = is_instr ? instr_rvalid : data_rvalid;
      gnt    = is_instr ? instr_gnt : data_gnt;
      check_value({pfx, "_gnt_o"}, 32'd0, gnt);
      if (!rvalid) begin
        check_value({pfx, "_wb_stb_o"}, 32'd1, stb);
        check_value({pfx, "_wb_cyc_o"}, 32'd1, cyc);
      end
      if (cnt == 1) begin
        check_value({pfx, "_wb_adr_o"}, addr, is_instr ? instr_wb_adr : data_wb_adr);
        if (!is_instr) begin
          check_value("data_wb_we_o", 32'(v[227:224] == 4'h2), data_wb_we);
          check_value("data_wb_sel_o", 32'(v[159:156]), data_wb_sel);
          if (v[227:224] == 4'h2) begin
            check_value("data_wb_dat_o", v[191:160], data_wb_dat_w);
          end
        end
      end
      if (ack) begin
        ack_at = cnt;
      end
      if (cnt > `CB_TIMEOUT_CYCLES + 8) begin
        abort_run($sformatf("No %s response arrived for address %h", pfx, addr));
      end
    end while (!rvalid);
    // Response cycle
    check_value({pfx, "_wb_stb_o"}, 32'd0, stb);
    check_value({pfx, "_wb_cyc_o"}, 32'd0, cyc);
    check_value({pfx, "_rdata_o"}, v[71:40], is_instr ? instr_rdata : data_rdata);
    check_value({pfx, "_err_o"}, 32'(v[39:36]), is_instr ? instr_err : data_err);
    if (delay == 8'hff) begin
      check_value({pfx, "_timeout_latency"}, `CB_TIMEOUT_CYCLES + 1, 32'(cnt - 1));
    end else begin
      check_value({pfx, "_ack_to_rvalid"}, 32'd1, 32'(cnt - ack_at));
    end
    @(posedge clk);
    instr_req <= 1'b0;
    data_req  <= 1'b0;
    data_we   <= 1'b0;
    // Valid lasts a single cycle
    @(negedge clk);
    check_value({pfx, "_rvalid_o"}, 32'd0, is_instr ? instr_rvalid : data_rvalid);
  endtask

  // ------------------------------------------------------------
  // Interrupt step for kind 3
  // ------------------------------------------------------------
  task automatic expect_irq_outputs(input logic [31:0] exp_irq, input logic [31:0] exp_dbg);
    check_value("irq_software_o", 32'(exp_irq[`CB_IRQ_SW]), irq_software);
    check_value("irq_timer_o", 32'(exp_irq[`CB_IRQ_TIMER]), irq_timer);
    check_value("irq_external_o", 32'(exp_irq[`CB_IRQ_EXT]), irq_external);
    check_value("irq_fast_o", 32'(exp_irq[`CB_IRQ_FAST_HI:`CB_IRQ_FAST_LO]), irq_fast);
    check_value("irq_nm_o", 32'(exp_irq[`CB_IRQ_NM]), irq_nm);
    check_value("debug_req_o", exp_dbg, debug_req);
  endtask

  task automatic run_irq(input logic [227:0] v);
    logic [31:0] exp_irq;
    exp_irq = v[35:4];
    @(posedge clk);
    irq_a       <= v[147:116];
    irq_b       <= v[115:84];
    debug_req_a <= v[80];
    debug_req_b <= v[81];
    irq_ack     <= v[79];
    irq_id      <= v[76:72];
    // Ack pulse of one cycle with sources held
    @(posedge clk);
    irq_ack <= 1'b0;
    @(negedge clk);
    expect_irq_outputs(exp_irq, 32'(v[3:0]));
    // Source still high sets its bit again one edge after the clear
    @(negedge clk);
    expect_irq_outputs(exp_irq | v[147:116] | v[115:84], 32'(v[3:0]));
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    seed = 32'h4706_c856;
    gap  = $urandom(seed);
    clk  = 1'b0;
    rst  = 1'b1;
    instr_req   = 1'b0;
    instr_addr  = '0;
    instr_delay = '0;
    data_req    = 1'b0;
    data_we     = 1'b0;
    data_be     = '0;
    data_addr   = '0;
    data_wdata  = '0;
    data_delay  = '0;
    irq_a       = '0;
    irq_b       = '0;
    irq_ack     = 1'b0;
    irq_id      = '0;
    debug_req_a = 1'b0;
    debug_req_b = 1'b0;
    $readmemh("core_bus_input.txt", vectors);
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    // Quiet outputs straight after reset
    @(negedge clk);
    check_value("instr_rvalid_o", 32'd0, instr_rvalid);
    check_value("data_rvalid_o", 32'd0, data_rvalid);
    check_value("instr_wb_stb_o", 32'd0, instr_wb_stb);
    check_value("data_wb_cyc_o", 32'd0, data_wb_cyc);
    check_value("irq_nm_o", 32'd0, irq_nm);
    check_value("debug_req_o", 32'd0, debug_req);
    for (int i = 0; i < NUM_VEC; i++) begin
      vec = vectors[i];
      gap = $urandom % 4;
      repeat (gap) @(posedge clk);
      case (vec[227:224])
        4'h0, 4'h1, 4'h2: run_bus(vec);
        4'h3: run_irq(vec);
        default: abort_run($sformatf("Vector %0d has an unknown step kind", i));
      endcase
    end
    $display("Done: no errors");
    $finish;
  end

  // Watchdog sized from the vector count
  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    abort_run("Watchdog expired before all vectors were run");
  end

endmodule
